/* common/mpu_pkg.sv */
// Shared types, FSM states, PMA region table and debug window constants for the MPU

package mpu_pkg;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [29:0] word_addr_t;
  typedef logic [1:0]  region_idx_t;
  typedef logic [1:0]  outstanding_cnt_t;

  // Error response sequencing
  typedef enum logic [1:0] {
    MPU_IDLE     = 2'b00,
    MPU_ERR_WAIT = 2'b01,
    MPU_ERR_RESP = 2'b10
  } mpu_state_e;

  ////////////////////////////////////////////////////////////
  // Region table
  ////////////////////////////////////////////////////////////

  localparam int PMA_NUM_REGIONS = 4;

  // Word bounds, low inclusive and high exclusive
  // R0 0x0000_0000..0x0001_0000, R1 0x0000_8000..0x0002_0000 (overlaps R0)
  // R2 0x1000_0000..0x1000_1000, R3 0x2000_0000..0x3000_0000
  localparam word_addr_t PMA_WORD_LOW [PMA_NUM_REGIONS] = '{
    30'h0000_0000,
    30'h0000_2000,
    30'h0400_0000,
    30'h0800_0000
  };

  localparam word_addr_t PMA_WORD_HIGH [PMA_NUM_REGIONS] = '{
    30'h0000_4000,
    30'h0000_8000,
    30'h0400_0400,
    30'h0C00_0000
  };

  // Attribute masks, bit i belongs to region i
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_MAIN       = 4'b1011;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_BUFFERABLE = 4'b1110;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_CACHEABLE  = 4'b1001;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_ATOMIC     = 4'b1011;

  ////////////////////////////////////////////////////////////
  // Debug module window and bus limits
  ////////////////////////////////////////////////////////////

  // Both bounds inclusive
  localparam addr_t DM_REGION_START = 32'hF000_0000;
  localparam addr_t DM_REGION_END   = 32'hF000_3FFF;

  // Highest number of bus transactions awaiting a response
  localparam outstanding_cnt_t OUTSTANDING_MAX = 2'd2;

endpackage

/* common/core_req_if.sv */
// Core request interface carrying address and access flags, with source and sink modports

`timescale 1ns/1ps

interface core_req_if;

  mpu_pkg::addr_t addr;
  logic           instr;
  logic           load;
  logic           atomic;
  logic           misaligned;
  logic           dbg;

  // Driven from the top level ports
  modport src (
    output addr,
    output instr,
    output load,
    output atomic,
    output misaligned,
    output dbg
  );

  // Read by the attribute checker
  modport dst (
    input addr,
    input instr,
    input load,
    input atomic,
    input misaligned,
    input dbg
  );

endinterface

/* pma/pma_check.sv */
// PMA region lookup with priority, debug window override, access error and bus attribute logic

`timescale 1ns/1ps

module pma_check (
  core_req_if.dst req,
  output logic    pma_err_o,
  output logic    attr_bufferable_o,
  output logic    attr_cacheable_o
);

  mpu_pkg::word_addr_t  word_addr;
  logic                 in_dm_window;
  logic                 match_found;
  mpu_pkg::region_idx_t match_idx;
  logic                 attr_main;
  logic                 attr_bufferable;
  logic                 attr_cacheable;
  logic                 attr_atomic;
  logic                 store_access;

  // Bits 1:0 take no part in the region match
  assign word_addr = req.addr[31:2];

  assign in_dm_window = req.dbg &&
                        (req.addr >= mpu_pkg::DM_REGION_START) &&
                        (req.addr <= mpu_pkg::DM_REGION_END);

  ////////////////////////////////////////////////////////////
  // Region search
  ////////////////////////////////////////////////////////////

  // Walk from the top so the lowest matching index is left standing
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = mpu_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((word_addr >= mpu_pkg::PMA_WORD_LOW[i]) &&
          (word_addr <  mpu_pkg::PMA_WORD_HIGH[i])) begin
        match_found = 1'b1;
        match_idx   = mpu_pkg::region_idx_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Attribute selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (in_dm_window) begin
      // Debug module is treated as plain main memory
      attr_main       = 1'b1;
      attr_bufferable = 1'b0;
      attr_cacheable  = 1'b0;
      attr_atomic     = 1'b0;
    end else if (match_found) begin
      attr_main       = mpu_pkg::PMA_MAIN[match_idx];
      attr_bufferable = mpu_pkg::PMA_BUFFERABLE[match_idx];
      attr_cacheable  = mpu_pkg::PMA_CACHEABLE[match_idx];
      attr_atomic     = mpu_pkg::PMA_ATOMIC[match_idx];
    end else begin
      // Unmatched address defaults to I/O with nothing enabled
      attr_main       = 1'b0;
      attr_bufferable = 1'b0;
      attr_cacheable  = 1'b0;
      attr_atomic     = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Access rules
  ////////////////////////////////////////////////////////////

  assign pma_err_o = (req.instr      && !attr_main)   ||
                     (req.misaligned && !attr_main)   ||
                     (req.atomic     && !attr_atomic) ||
                     (req.misaligned && req.atomic);

  // Only plain data stores may be posted
  assign store_access = !req.instr && !req.load && !req.atomic;

  assign attr_bufferable_o = attr_bufferable && store_access;
  assign attr_cacheable_o  = attr_cacheable;

endmodule

/* design/mpu_err_fsm.sv */
// Outstanding response counter, error response FSM and core/bus handshake gating

`timescale 1ns/1ps

module mpu_err_fsm (
  input  logic clk,
  input  logic rst_n,

  // Core request handshake
  input  logic core_trans_valid_i,
  output logic core_trans_ready_o,

  // Attribute check results
  input  logic pma_err_i,
  input  logic attr_bufferable_i,
  input  logic attr_cacheable_i,

  // Bus request side
  output logic bus_trans_valid_o,
  input  logic bus_trans_ready_i,
  output logic bus_trans_bufferable_o,
  output logic bus_trans_cacheable_o,

  // Bus response side
  input  logic bus_resp_valid_i,
  input  logic bus_resp_err_i,

  // Core response
  output logic core_resp_valid_o,
  output logic core_resp_err_o
);

  mpu_pkg::mpu_state_e       state_q;
  mpu_pkg::mpu_state_e       state_d;
  mpu_pkg::outstanding_cnt_t cnt_q;
  mpu_pkg::outstanding_cnt_t cnt_d;
  logic                      idle;
  logic                      cnt_full;
  logic                      bus_hs;
  logic                      err_accept;
  logic                      err_resp;

  assign idle     = (state_q == mpu_pkg::MPU_IDLE);
  assign cnt_full = (cnt_q == mpu_pkg::OUTSTANDING_MAX);
  assign err_resp = (state_q == mpu_pkg::MPU_ERR_RESP);

  ////////////////////////////////////////////////////////////
  // Handshake gating
  ////////////////////////////////////////////////////////////

  // Faulting requests never reach the bus
  assign bus_trans_valid_o = core_trans_valid_i && idle && !pma_err_i && !cnt_full;

  // A faulting request is taken at once, the rest wait for the bus
  assign core_trans_ready_o = idle && (pma_err_i || (bus_trans_ready_i && !cnt_full));

  assign bus_trans_bufferable_o = bus_trans_valid_o && attr_bufferable_i;
  assign bus_trans_cacheable_o  = bus_trans_valid_o && attr_cacheable_i;

  assign bus_hs     = bus_trans_valid_o && bus_trans_ready_i;
  assign err_accept = core_trans_valid_i && core_trans_ready_o && pma_err_i;

  // Responses either come from the bus or from the FSM, never both
  assign core_resp_valid_o = bus_resp_valid_i || err_resp;
  assign core_resp_err_o   = err_resp || (bus_resp_valid_i && bus_resp_err_i);

  ////////////////////////////////////////////////////////////
  // Outstanding count and state
  ////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    if (bus_hs && !bus_resp_valid_i) begin
      cnt_d = cnt_q + 2'd1;
    end else if (!bus_hs && bus_resp_valid_i) begin
      cnt_d = cnt_q - 2'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (err_accept) begin
          state_d = (cnt_q == '0) ? mpu_pkg::MPU_ERR_RESP : mpu_pkg::MPU_ERR_WAIT;
        end
      end
      // Hold the error back until earlier bus responses are through
      mpu_pkg::MPU_ERR_WAIT: begin
        if (cnt_q == '0) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end
      mpu_pkg::MPU_ERR_RESP: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

/* design/mpu_top.sv */
// MPU top level with plain core and bus ports, request interface, PMA checker and error FSM

`timescale 1ns/1ps

module mpu_top (
  input  logic           clk,
  input  logic           rst_n,

  // Core request
  input  logic           core_trans_valid_i,
  output logic           core_trans_ready_o,
  input  mpu_pkg::addr_t core_addr_i,
  input  logic           core_instr_i,
  input  logic           core_load_i,
  input  logic           core_atomic_i,
  input  logic           core_misaligned_i,
  input  logic           core_dbg_i,

  // Bus request
  output logic           bus_trans_valid_o,
  input  logic           bus_trans_ready_i,
  output mpu_pkg::addr_t bus_addr_o,
  output logic           bus_trans_bufferable_o,
  output logic           bus_trans_cacheable_o,

  // Bus response
  input  logic           bus_resp_valid_i,
  input  logic           bus_resp_err_i,

  // Core response
  output logic           core_resp_valid_o,
  output logic           core_resp_err_o
);

  logic pma_err;
  logic attr_bufferable;
  logic attr_cacheable;

  core_req_if req_if ();

  assign req_if.addr       = core_addr_i;
  assign req_if.instr      = core_instr_i;
  assign req_if.load       = core_load_i;
  assign req_if.atomic     = core_atomic_i;
  assign req_if.misaligned = core_misaligned_i;
  assign req_if.dbg        = core_dbg_i;

  // Address is forwarded untouched, the FSM decides if it is valid
  assign bus_addr_o = core_addr_i;

  pma_check pma_check_i (
    .req               (req_if.dst),
    .pma_err_o         (pma_err),
    .attr_bufferable_o (attr_bufferable),
    .attr_cacheable_o  (attr_cacheable)
  );

  mpu_err_fsm mpu_err_fsm_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .core_trans_valid_i     (core_trans_valid_i),
    .core_trans_ready_o     (core_trans_ready_o),
    .pma_err_i              (pma_err),
    .attr_bufferable_i      (attr_bufferable),
    .attr_cacheable_i       (attr_cacheable),
    .bus_trans_valid_o      (bus_trans_valid_o),
    .bus_trans_ready_i      (bus_trans_ready_i),
    .bus_trans_bufferable_o (bus_trans_bufferable_o),
    .bus_trans_cacheable_o  (bus_trans_cacheable_o),
    .bus_resp_valid_i       (bus_resp_valid_i),
    .bus_resp_err_i         (bus_resp_err_i),
    .core_resp_valid_o      (core_resp_valid_o),
    .core_resp_err_o        (core_resp_err_o)
  );

endmodule

/* tb/tb_clk_gen.sv */
// Testbench clock source (8 ns period) and active low reset held for 10 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the capture edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tb/mpu_top_tb.sv */
// MPU testbench with directed test tasks, compare tasks, bus response model and timeout

`timescale 1ns/1ps

module mpu_top_tb;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RESP_WAIT_MAX  = 20;

  logic           clk;
  logic           rst_n;
  logic           core_trans_valid_i;
  logic           core_trans_ready_o;
  mpu_pkg::addr_t core_addr_i;
  logic           core_instr_i;
  logic           core_load_i;
  logic           core_atomic_i;
  logic           core_misaligned_i;
  logic           core_dbg_i;
  logic           bus_trans_valid_o;
  logic           bus_trans_ready_i;
  mpu_pkg::addr_t bus_addr_o;
  logic           bus_trans_bufferable_o;
  logic           bus_trans_cacheable_o;
  logic           bus_resp_valid_i;
  logic           bus_resp_err_i;
  logic           core_resp_valid_o;
  logic           core_resp_err_o;
  int             errors;
  int             checks;
  int             cycles;

  tb_clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

  mpu_top mpu_top_i (.*);

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks and helpers
  ////////////////////////////////////////////////////////////

  task automatic check_addr(input string name, input mpu_pkg::addr_t got,
                            input mpu_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic mpu_pkg::addr_t rand_r1_addr();
    // Upper half of R1, clear of the R0 overlap
    return (32'h0001_0000 + ($urandom % 32'h0001_0000)) & 32'hFFFF_FFFC;
  endfunction

  function automatic mpu_pkg::addr_t rand_r3_addr();
    return (32'h2000_0000 + ($urandom % 32'h1000_0000)) & 32'hFFFF_FFFC;
  endfunction

  task automatic drive_req(input mpu_pkg::addr_t addr, input logic instr, input logic load,
                           input logic atomic, input logic misaligned, input logic dbg);
    core_trans_valid_i = 1'b1;
    core_addr_i        = addr;
    core_instr_i       = instr;
    core_load_i        = load;
    core_atomic_i      = atomic;
    core_misaligned_i  = misaligned;
    core_dbg_i         = dbg;
  endtask

  // Bus model returns one response pulse, called on a falling edge
  task automatic bus_respond();
    bus_resp_valid_i = 1'b1;
    #1;
    check_bit("core_resp_valid_o", core_resp_valid_o, 1'b1);
    check_bit("core_resp_err_o", core_resp_err_o, 1'b0);
    @(negedge clk);
    bus_resp_valid_i = 1'b0;
  endtask

  task automatic wait_resp(input logic exp_err);
    int n;
    n = 0;
    #1;
    while (core_resp_valid_o !== 1'b1 && n < RESP_WAIT_MAX) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (core_resp_valid_o !== 1'b1) begin
      errors++;
      $display("No core response arrived within %0d cycles", RESP_WAIT_MAX);
    end else begin
      check_bit("core_resp_err_o", core_resp_err_o, exp_err);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  // Passing request with a stalled bus, then the response
  task automatic allowed_access(input mpu_pkg::addr_t addr, input logic instr,
                                input logic load, input logic atomic, input logic dbg,
                                input logic exp_buf, input logic exp_cache);
    @(negedge clk);
    bus_trans_ready_i = 1'b0;
    drive_req(addr, instr, load, atomic, 1'b0, dbg);
    repeat (3) begin
      #1;
      check_addr("bus_addr_o", bus_addr_o, addr);
      check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b1);
      check_bit("core_trans_ready_o", core_trans_ready_o, 1'b0);
      @(negedge clk);
    end
    bus_trans_ready_i = 1'b1;
    #1;
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    check_bit("bus_trans_bufferable_o", bus_trans_bufferable_o, exp_buf);
    check_bit("bus_trans_cacheable_o", bus_trans_cacheable_o, exp_cache);
    @(negedge clk);
    core_trans_valid_i = 1'b0;
    bus_trans_ready_i  = 1'b0;
    bus_respond();
  endtask

  // Faulting request is taken at once and answered one cycle later
  task automatic error_access(input mpu_pkg::addr_t addr, input logic instr, input logic load,
                              input logic atomic, input logic misaligned, input logic dbg);
    @(negedge clk);
    bus_trans_ready_i = 1'b0;
    drive_req(addr, instr, load, atomic, misaligned, dbg);
    #1;
    check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b0);
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    check_bit("core_resp_valid_o", core_resp_valid_o, 1'b0);
    @(negedge clk);
    core_trans_valid_i = 1'b0;
    #1;
    check_bit("core_resp_valid_o", core_resp_valid_o, 1'b1);
    check_bit("core_resp_err_o", core_resp_err_o, 1'b1);
    @(negedge clk);
    #1;
    check_bit("core_resp_valid_o", core_resp_valid_o, 1'b0);
  endtask

  task automatic err_behind_outstanding();
    mpu_pkg::addr_t addr;
    addr = rand_r3_addr();
    @(negedge clk);
    bus_trans_ready_i = 1'b1;
    drive_req(addr, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    #1;
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    @(negedge clk);
    // Fetch from R2 while the store is still open
    drive_req(32'h1000_0040, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    #1;
    check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b0);
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    @(negedge clk);
    drive_req(addr, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (4) begin
      #1;
      check_bit("core_resp_valid_o", core_resp_valid_o, 1'b0);
      check_bit("core_trans_ready_o", core_trans_ready_o, 1'b0);
      check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b0);
      @(negedge clk);
    end
    bus_respond();
    wait_resp(1'b1);
    @(negedge clk);
    #1;
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b1);
    @(negedge clk);
    core_trans_valid_i = 1'b0;
    bus_respond();
  endtask

  task automatic outstanding_limit();
    @(negedge clk);
    bus_trans_ready_i = 1'b1;
    drive_req(rand_r3_addr(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    #1;
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    @(negedge clk);
    drive_req(rand_r3_addr(), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    #1;
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    @(negedge clk);
    drive_req(rand_r1_addr(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (2) begin
      #1;
      check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b0);
      check_bit("core_trans_ready_o", core_trans_ready_o, 1'b0);
      @(negedge clk);
    end
    bus_respond();
    #1;
    check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b1);
    check_bit("core_trans_ready_o", core_trans_ready_o, 1'b1);
    @(negedge clk);
    core_trans_valid_i = 1'b0;
    bus_trans_ready_i  = 1'b0;
    bus_respond();
    bus_respond();
  endtask

  initial begin
    errors = 0;
    checks = 0;
    cycles = 0;
    void'($urandom(85180));
    core_trans_valid_i = 1'b0;
    core_addr_i        = '0;
    core_instr_i       = 1'b0;
    core_load_i        = 1'b0;
    core_atomic_i      = 1'b0;
    core_misaligned_i  = 1'b0;
    core_dbg_i         = 1'b0;
    bus_trans_ready_i  = 1'b0;
    bus_resp_valid_i   = 1'b0;
    bus_resp_err_i     = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    #1;
    check_bit("core_resp_valid_o", core_resp_valid_o, 1'b0);
    check_bit("bus_trans_valid_o", bus_trans_valid_o, 1'b0);

    // Stores and loads to R1 and R3
    allowed_access(rand_r1_addr(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    allowed_access(rand_r1_addr(), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    allowed_access(rand_r3_addr(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    allowed_access(rand_r3_addr(), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    allowed_access(rand_r3_addr(), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    // R0 wins the overlap, R1 alone above it
    allowed_access(32'h0000_9000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    allowed_access(32'h0001_8000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    // Access rule violations
    error_access(32'h1000_0100, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    error_access(32'h1000_0200, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    error_access(32'h4000_0001, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    error_access(32'h0000_0102, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
    // Debug window, a fetch only passes as main memory
    allowed_access(32'hF000_1000, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    error_access(32'hF000_1000, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    error_access(32'hF000_1000, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    err_behind_outstanding();
    outstanding_limit();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* mpu_lite.f */
common/mpu_pkg.sv
common/core_req_if.sv
pma/pma_check.sv
design/mpu_err_fsm.sv
design/mpu_top.sv
tb/tb_clk_gen.sv
tb/mpu_top_tb.sv
